// File: Bender.yml
package:
  name: cart_mapper

sources:
  - src/mapper_pkg.sv
  - src/mapper_if.sv
  - src/cpu_write_decode.sv
  - src/bank_regs.sv
  - src/scanline_irq.sv
  - src/addr_translate.sv
  - src/cart_mapper.sv
  - target: test
    files:
      - tests/tb_cart_mapper.sv

// File: cart_mapper.f
src/mapper_pkg.sv
src/mapper_if.sv
src/cpu_write_decode.sv
src/bank_regs.sv
src/scanline_irq.sv
src/addr_translate.sv
src/cart_mapper.sv
tests/tb_cart_mapper.sv

// File: src/addr_translate.sv
module addr_translate #(
	parameter int USE_MMC3 = 1
) (
	input  logic         m2,
	input  logic         romsel,
	input  logic         cpu_rw_in,
	input  logic [14:0]  cpu_addr_in,
	input  logic         ppu_rd_in,
	input  logic         ppu_wr_in,
	input  logic [13:0]  ppu_addr,
	bank_state_if.translate st,
	output logic [26:13] cpu_addr_out,
	output logic         flash_we,
	output logic         flash_oe,
	output logic         sram_ce,
	output logic         sram_we,
	output logic         sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic         ppu_rd_out,
	output logic         ppu_wr_out,
	output logic         ppu_ciram_a10
);
	import mapper_pkg::*;

	logic                  mmc3_on;	// MMC3 id and built in
	logic [PRG_PAGE_W-1:0] prg_page;	// A18:13 before base
	logic [CHR_PAGE_W-1:0] chr_page;	// A17:10 before mask
	logic [2:0]            chr_sel;	// 1K bank index

	assign mmc3_on = (USE_MMC3 != 0) && (st.mapper == MAP_MMC3);
	assign chr_sel = {1'b0, ppu_addr[11:10]} + 3'd2;	// Banks 2-5

	always_comb
	begin
		if (mmc3_on)
		begin
			case ({cpu_addr_in[14:13], st.prg_mode})
			3'b000, 3'b101: prg_page = st.r6[5:0];
			3'b001, 3'b100: prg_page = 6'b111110;	// Second to last
			3'b010, 3'b011: prg_page = st.r7[5:0];
			default: prg_page = 6'b111111;	// $E000 fixed last
			endcase
		end
		else if (st.mapper == MAP_AXROM)
			prg_page = {st.r1[3:0], cpu_addr_in[14:13]};	// 32K
		else
			prg_page = {(cpu_addr_in[14] ? 5'b11111 : st.r1[4:0]), cpu_addr_in[13]};	// 16K+fixed
	end

	always_comb
	begin
		if (!mmc3_on)
			chr_page = {st.r0[4:0], ppu_addr[12:10]};	// 8K
		else if (ppu_addr[12] == st.chr_mode)	// 2K half
			chr_page = ppu_addr[11] ? {st.chr_bank[1][7:1], ppu_addr[10]}
				: {st.chr_bank[0][7:1], ppu_addr[10]};
		else
			chr_page = st.chr_bank[chr_sel];	// 1K half
	end

	assign cpu_addr_out = !romsel
		? {st.prg_base | {{(PRG_BASE_W - BANK_MASK_W){1'b0}},
			prg_page[PRG_PAGE_W-1:1] & ~st.prg_mask}, prg_page[0]}
		: {12'd0, st.sram_page};	// SRAM page for $6000
	assign ppu_addr_out = {chr_page[7:3] & ~st.chr_mask, chr_page[2:0]};

	assign flash_we = cpu_rw_in | romsel | ~st.prg_write_enabled;
	assign flash_oe = ~cpu_rw_in | romsel;
	assign sram_ce = ~(cpu_addr_in[14] & cpu_addr_in[13] & m2 & romsel & st.sram_enabled);
	assign sram_we = cpu_rw_in;
	assign sram_oe = ~cpu_rw_in;
	assign ppu_rd_out = ppu_rd_in | ppu_addr[13];	// CHR below $2000 only
	assign ppu_wr_out = ppu_wr_in | ppu_addr[13] | ~st.chr_write_enabled;

	always_comb
	begin
		case (st.mirroring)
		MIR_VERT: ppu_ciram_a10 = ppu_addr[10];
		MIR_HORZ: ppu_ciram_a10 = ppu_addr[11];
		MIR_ONE_A: ppu_ciram_a10 = 1'b0;
		default: ppu_ciram_a10 = 1'b1;	// MIR_ONE_B
		endcase
	end

endmodule

// File: src/bank_regs.sv
module bank_regs (
	input  logic       m2,
	input  logic       ppu_addr_in,	// Async reset
	cpu_wr_if.regs     wr,
	bank_state_if.regs st,
	output logic       lockout,
	output logic [7:0] irq_latch,
	output logic       irq_reload,	// One m2 cycle
	output logic       irq_enable
);
	import mapper_pkg::*;

	logic [2:0] mmc3_index;	// Target of MMC3_DATA

	assign wr.mapper = st.mapper;	// Decode follows current id

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			st.prg_base <= '0;
			st.prg_mask <= '0;
			st.chr_mask <= '0;
			st.sram_page <= '0;
			st.mapper <= MAPPER_RESET;
			st.mirroring <= MIRROR_RESET;
			st.sram_enabled <= 1'b0;
			st.prg_write_enabled <= 1'b0;
			st.chr_write_enabled <= 1'b0;
			st.r0 <= '0;
			st.r1 <= '0;
			st.r6 <= '0;
			st.r7 <= '0;
			st.chr_bank <= '0;
			st.prg_mode <= 1'b0;
			st.chr_mode <= 1'b0;
			mmc3_index <= '0;
			lockout <= 1'b0;
			irq_latch <= '0;
			irq_reload <= 1'b0;
			irq_enable <= 1'b0;
		end
		else
		begin
			irq_reload <= 1'b0;	// Strobe default
			if (wr.valid)
			begin
				case (wr.target)
				CFG_BASE_HI: st.prg_base[12:8] <= wr.data[4:0];	// A26:22
				CFG_BASE_LO: st.prg_base[7:0] <= wr.data;	// A21:14
				CFG_PRG_MASK: st.prg_mask <= wr.data[4:0];
				CFG_CHR_BANK: st.r0 <= wr.data;
				CFG_CHR_MASK: st.chr_mask <= wr.data[4:0];
				CFG_PRG_SRAM:
				begin
					st.r1[5:0] <= wr.data[7:2];
					st.sram_page <= wr.data[1:0];
				end
				CFG_MAPPER: st.mapper <= mapper_e'(wr.data[4:0]);	// Bits 7:5 ignored
				CFG_MODE:
				begin
					lockout <= wr.data[7];	// Sticky until reset
					st.mirroring <= mirror_e'(wr.data[4:3]);
					st.prg_write_enabled <= wr.data[2];
					st.chr_write_enabled <= wr.data[1];
					st.sram_enabled <= wr.data[0];
				end
				WR_SIMPLE_BANK:
				begin
					case (st.mapper)
					MAP_UXROM: st.r1 <= wr.data;	// 16K at $8000
					MAP_CNROM: st.r0 <= wr.data;	// 8K CHR
					MAP_AXROM:
					begin
						st.r1[4:0] <= wr.data[4:0];	// 32K PRG
						st.mirroring <= mirror_e'({1'b1, wr.data[4]});	// One-screen
					end
					default: ;
					endcase
				end
				MMC3_SELECT:
				begin
					mmc3_index <= wr.data[2:0];
					st.prg_mode <= wr.data[6];
					st.chr_mode <= wr.data[7];
				end
				MMC3_DATA:
				begin
					case (mmc3_index)
					3'd6: st.r6 <= wr.data;
					3'd7: st.r7 <= wr.data;
					default: st.chr_bank[mmc3_index] <= wr.data;	// R0-R5
					endcase
				end
				MMC3_MIRROR: st.mirroring <= mirror_e'({1'b0, wr.data[0]});	// V or H
				MMC3_IRQ_LATCH: irq_latch <= wr.data;
				MMC3_IRQ_RELOAD: irq_reload <= 1'b1;
				MMC3_IRQ_OFF: irq_enable <= 1'b0;	// Also acks
				MMC3_IRQ_ON: irq_enable <= 1'b1;
				default: ;
				endcase
			end
		end
	end

	// Decoder must drop $5xx6 once locked
	a_lockout_mapper: assert property (@(posedge m2) disable iff (ppu_addr_in)
		lockout |=> $stable(st.mapper))
		else $error("mapper id changed under lockout");

endmodule

// File: src/cart_mapper.sv
module cart_mapper #(
	parameter int USE_MMC3           = 1,
	parameter int IRQ_A12_LOW_CYCLES = 3
) (
	input  logic         m2,
	input  logic         romsel,
	input  logic         cpu_rw_in,
	input  logic [14:0]  cpu_addr_in,
	input  logic [7:0]   cpu_data_in,
	output logic [26:13] cpu_addr_out,
	output logic         flash_we,
	output logic         flash_oe,
	output logic         sram_ce,
	output logic         sram_we,
	output logic         sram_oe,
	input  logic         ppu_addr_in,	// Reset, active high
	input  logic         ppu_rd_in,
	input  logic         ppu_wr_in,
	input  logic [13:0]  ppu_addr,
	output logic [17:10] ppu_addr_out,
	output logic         ppu_rd_out,
	output logic         ppu_wr_out,
	output logic         ppu_ciram_a10,
	output wire          irq	// Open drain
);
	logic       lockout;
	logic [7:0] irq_latch;
	logic       irq_reload;
	logic       irq_enable;
	logic       irq_active;

	cpu_wr_if     wr_bus ();
	bank_state_if st_bus ();

	cpu_write_decode #(.USE_MMC3(USE_MMC3)) u_decode (
		.romsel(romsel), .cpu_rw_in(cpu_rw_in), .cpu_addr_in(cpu_addr_in),
		.cpu_data_in(cpu_data_in), .lockout(lockout), .wr(wr_bus.decode));

	bank_regs u_regs (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .wr(wr_bus.regs), .st(st_bus.regs),
		.lockout(lockout), .irq_latch(irq_latch), .irq_reload(irq_reload),
		.irq_enable(irq_enable));

	scanline_irq #(.IRQ_A12_LOW_CYCLES(IRQ_A12_LOW_CYCLES)) u_irq (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .a12(ppu_addr[12]), .irq_latch(irq_latch),
		.irq_reload(irq_reload), .irq_enable(irq_enable), .irq_active(irq_active));

	addr_translate #(.USE_MMC3(USE_MMC3)) u_xlate (
		.m2(m2), .romsel(romsel), .cpu_rw_in(cpu_rw_in), .cpu_addr_in(cpu_addr_in),
		.ppu_rd_in(ppu_rd_in), .ppu_wr_in(ppu_wr_in), .ppu_addr(ppu_addr),
		.st(st_bus.translate), .cpu_addr_out(cpu_addr_out), .flash_we(flash_we),
		.flash_oe(flash_oe), .sram_ce(sram_ce), .sram_we(sram_we), .sram_oe(sram_oe),
		.ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out), .ppu_wr_out(ppu_wr_out),
		.ppu_ciram_a10(ppu_ciram_a10));

	assign irq = irq_active ? 1'b0 : 1'bz;	// Pull low or release

endmodule

// File: src/cpu_write_decode.sv
module cpu_write_decode #(
	parameter int USE_MMC3 = 1
) (
	input  logic        romsel,
	input  logic        cpu_rw_in,
	input  logic [14:0] cpu_addr_in,
	input  logic [7:0]  cpu_data_in,
	input  logic        lockout,
	cpu_wr_if.decode    wr
);
	import mapper_pkg::*;

	logic       hit;	// Cycle addresses a register
	wr_target_e target;

	always_comb
	begin
		hit = 1'b0;
		target = CFG_BASE_HI;
		if (romsel)	// $0000-$7FFF
		begin
			if (cpu_addr_in[14:12] == 3'b101 && !lockout)	// $5xxx, unlocked
			begin
				hit = 1'b1;
				target = wr_target_e'({1'b0, cpu_addr_in[2:0]});	// CFG slot by A2:0
			end
		end
		else	// $8000-$FFFF
		begin
			case (wr.mapper)
			MAP_UXROM, MAP_CNROM, MAP_AXROM:
			begin
				hit = 1'b1;
				target = WR_SIMPLE_BANK;	// Any address latches
			end
			MAP_MMC3:
			begin
				if (USE_MMC3 != 0)
				begin
					hit = 1'b1;
					case ({cpu_addr_in[14:13], cpu_addr_in[0]})
					3'b000: target = MMC3_SELECT;	// $8000 even
					3'b001: target = MMC3_DATA;	// $8001 odd
					3'b010: target = MMC3_MIRROR;	// $A000 even
					3'b100: target = MMC3_IRQ_LATCH;	// $C000 even
					3'b101: target = MMC3_IRQ_RELOAD;
					3'b110: target = MMC3_IRQ_OFF;	// $E000 even
					3'b111: target = MMC3_IRQ_ON;
					default: hit = 1'b0;	// $A001 RAM protect, not kept
					endcase
				end
			end
			default: ;	// NROM and unknown ids, no registers
			endcase
		end
	end

	assign wr.valid = hit && !cpu_rw_in;	// Writes only
	assign wr.target = target;
	assign wr.data = cpu_data_in;

	// Locked config space never yields a command
	always_comb
	begin
		a_valid_write: assert final (!wr.valid || (!cpu_rw_in && (!romsel || !lockout)))
			else $error("write command on a read or locked cycle");
	end

endmodule

// File: src/mapper_if.sv
// Write command from the bus decoder to the register file
interface cpu_wr_if;
	import mapper_pkg::*;

	logic       valid;	// One write this m2 cycle
	wr_target_e target;
	logic [7:0] data;
	mapper_e    mapper;	// Current id, fed back to decode

	modport decode (output valid, output target, output data, input mapper);
	modport regs (input valid, input target, input data, output mapper);
endinterface

// Register state seen by the address translation
interface bank_state_if;
	import mapper_pkg::*;

	logic [PRG_BASE_W-1:0]  prg_base;	// Base for A26:14
	logic [BANK_MASK_W-1:0] prg_mask;
	logic [BANK_MASK_W-1:0] chr_mask;
	logic [1:0]             sram_page;
	mapper_e                mapper;
	mirror_e                mirroring;
	logic                   sram_enabled;
	logic                   prg_write_enabled;
	logic                   chr_write_enabled;
	logic [7:0]             r0;		// Simple CHR bank
	logic [7:0]             r1;		// Simple PRG bank
	logic [7:0]             r6;		// MMC3 PRG bank 0
	logic [7:0]             r7;		// MMC3 PRG bank 1
	logic [5:0][7:0]        chr_bank;	// MMC3 CHR banks 0-5
	logic                   prg_mode;	// MMC3 $8000/$C000 swap
	logic                   chr_mode;	// MMC3 A12 inversion

	modport regs (output prg_base, prg_mask, chr_mask, sram_page, mapper, mirroring,
		sram_enabled, prg_write_enabled, chr_write_enabled, r0, r1, r6, r7, chr_bank,
		prg_mode, chr_mode);
	modport translate (input prg_base, prg_mask, chr_mask, sram_page, mapper, mirroring,
		sram_enabled, prg_write_enabled, chr_write_enabled, r0, r1, r6, r7, chr_bank,
		prg_mode, chr_mode);
endinterface

// File: src/mapper_pkg.sv
package mapper_pkg;

	localparam int PRG_BASE_W  = 13;	// Output address bits 26:14
	localparam int PRG_PAGE_W  = 6;	// 8K PRG page, bits 18:13
	localparam int CHR_PAGE_W  = 8;	// 1K CHR page, bits 17:10
	localparam int BANK_MASK_W = 5;	// PRG and CHR masks

	// Mapper ids as written to $5xx6
	typedef enum logic [4:0] {
		MAP_NROM  = 5'b00000,
		MAP_UXROM = 5'b00001,
		MAP_CNROM = 5'b00010,
		MAP_AXROM = 5'b01000,
		MAP_MMC3  = 5'b10100
	} mapper_e;

	// Destination of one decoded CPU write
	typedef enum logic [3:0] {
		CFG_BASE_HI,		// $5xx0, CFG slots follow A2:0
		CFG_BASE_LO,
		CFG_PRG_MASK,
		CFG_CHR_BANK,
		CFG_CHR_MASK,
		CFG_PRG_SRAM,
		CFG_MAPPER,
		CFG_MODE,		// $5xx7
		WR_SIMPLE_BANK,	// UxROM, CNROM, AxROM latch
		MMC3_SELECT,
		MMC3_DATA,
		MMC3_MIRROR,
		MMC3_IRQ_LATCH,
		MMC3_IRQ_RELOAD,
		MMC3_IRQ_OFF,
		MMC3_IRQ_ON
	} wr_target_e;

	typedef enum logic [1:0] {
		MIR_VERT  = 2'b00,	// CIRAM A10 from PPU A10
		MIR_HORZ  = 2'b01,	// From PPU A11
		MIR_ONE_A = 2'b10,	// One-screen, page 0
		MIR_ONE_B = 2'b11	// One-screen, page 1
	} mirror_e;

	localparam mapper_e MAPPER_RESET = MAP_NROM;	// Plain 32K after power-up
	localparam mirror_e MIRROR_RESET = MIR_VERT;

endpackage

// File: src/scanline_irq.sv
module scanline_irq #(
	parameter int IRQ_A12_LOW_CYCLES = 3
) (
	input  logic       m2,
	input  logic       ppu_addr_in,	// Async reset
	input  logic       a12,	// PPU A12
	input  logic [7:0] irq_latch,
	input  logic       irq_reload,
	input  logic       irq_enable,
	output logic       irq_active
);
	localparam int LOW_W = $clog2(IRQ_A12_LOW_CYCLES + 1);

	logic [LOW_W-1:0] low_time;	// Saturating count of low samples
	logic [7:0]       counter;	// Scanline down-counter
	logic [7:0]       counter_next;
	logic             reload_pending;	// Held until next A12 clock
	logic             pending_now;
	logic             irq_flag;
	logic             a12_clock;	// Filtered rise

	assign a12_clock = a12 && (low_time == LOW_W'(IRQ_A12_LOW_CYCLES));	// High after long low
	assign pending_now = reload_pending || irq_reload;	// Strobe on the clock edge counts
	assign counter_next = (pending_now || counter == 8'd0) ? irq_latch : counter - 8'd1;
	assign irq_active = irq_flag && irq_enable;	// Released as soon as disabled

	// A12 low-time filter
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
			low_time <= '0;
		else if (a12)
			low_time <= '0;	// Any high sample restarts
		else if (low_time != LOW_W'(IRQ_A12_LOW_CYCLES))
			low_time <= low_time + 1'b1;
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			counter <= '0;
			reload_pending <= 1'b0;
			irq_flag <= 1'b0;
		end
		else
		begin
			if (a12_clock)
			begin
				counter <= counter_next;
				reload_pending <= 1'b0;	// Consumed
				if (counter_next == 8'd0 && irq_enable)
					irq_flag <= 1'b1;	// Same edge as reaching 0
			end
			else if (irq_reload)
				reload_pending <= 1'b1;
			if (!irq_enable)
				irq_flag <= 1'b0;	// Ack from $E000
		end
	end

	// IRQ rises only on an enabled A12 clock that brings the counter to 0
	a_irq_needs_enable: assert property (@(posedge m2) disable iff (ppu_addr_in)
		$rose(irq_active) |-> $past(a12_clock && irq_enable) && counter == 8'd0)
		else $error("scanline IRQ raised without an enabled A12 clock at zero");

endmodule

// File: tests/tb_cart_mapper.sv
module tb_cart_mapper;
	timeunit 1ns;
	timeprecision 100ps;

	logic        m2;
	logic        romsel;
	logic        cpu_rw_in;
	logic [14:0] cpu_addr_in;
	logic [7:0]  cpu_data_in;
	logic [26:13] cpu_addr_out;
	logic        flash_we;
	logic        flash_oe;
	logic        sram_ce;
	logic        sram_we;
	logic        sram_oe;
	logic        ppu_addr_in;	// Reset
	logic        ppu_rd_in;
	logic        ppu_wr_in;
	logic [13:0] ppu_addr;
	logic [17:10] ppu_addr_out;
	logic        ppu_rd_out;
	logic        ppu_wr_out;
	logic        ppu_ciram_a10;
	wire         irq;

	int     checks = 0;
	int     errors = 0;
	int     timeouts = 0;
	integer seed = 32'h25a2_cb4f;
	int     row;

	// Stimulus table with one entry per row
	string       q_name[$];
	logic        q_chk[$];	// Probe and compare
	logic [15:0] q_wa[$];	// CPU write address, A15 from romsel
	logic [7:0]  q_wd[$];
	logic [15:0] q_pa[$];	// CPU probe address
	logic [13:0] q_ppu[$];	// PPU probe address
	logic [13:0] q_ecpu[$];	// Expected A26:13
	logic [7:0]  q_eppu[$];	// Expected A17:10
	logic        q_ea10[$];	// Expected CIRAM A10

	pullup (irq);	// Open-drain IRQ line

	cart_mapper #(.USE_MMC3(1), .IRQ_A12_LOW_CYCLES(3)) u_dut (
		.m2(m2), .romsel(romsel), .cpu_rw_in(cpu_rw_in), .cpu_addr_in(cpu_addr_in),
		.cpu_data_in(cpu_data_in), .cpu_addr_out(cpu_addr_out), .flash_we(flash_we),
		.flash_oe(flash_oe), .sram_ce(sram_ce), .sram_we(sram_we), .sram_oe(sram_oe),
		.ppu_addr_in(ppu_addr_in), .ppu_rd_in(ppu_rd_in), .ppu_wr_in(ppu_wr_in),
		.ppu_addr(ppu_addr), .ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out), .ppu_ciram_a10(ppu_ciram_a10), .irq(irq));

	initial
	begin
		m2 = 1'b0;
		forever #5 m2 = ~m2;	// 100 MHz
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic add_row(input string name, input logic [15:0] wa, input logic [7:0] wd,
		input logic [15:0] pa, input logic [13:0] ppu, input logic [13:0] ecpu,
		input logic [7:0] eppu, input logic ea10);
		q_name.push_back(name);
		q_chk.push_back(1'b1);
		q_wa.push_back(wa);
		q_wd.push_back(wd);
		q_pa.push_back(pa);
		q_ppu.push_back(ppu);
		q_ecpu.push_back(ecpu);
		q_eppu.push_back(eppu);
		q_ea10.push_back(ea10);
	endtask

	task automatic add_write(input logic [15:0] wa, input logic [7:0] wd);
		add_row("write_only", wa, wd, 16'h8000, 14'h0000, 14'h0000, 8'h00, 1'b0);
		q_chk[$] = 1'b0;	// No probe
	endtask

	task automatic build_table();
		int          i;
		logic [31:0] r;
		logic [13:0] pa;
		// Configuration under NROM with base 0x1540 after both halves
		add_row("base_hi", 16'h5000, 8'h15, 16'h8000, 14'h0000, {13'h1500, 1'b0}, 8'h00, 0);
		add_row("base_lo", 16'h5001, 8'h40, 16'hC000, 14'h0400, {13'h155F, 1'b0}, 8'h01, 1);
		add_row("prg_mask", 16'h5002, 8'h1C, 16'hE000, 14'h0800, {13'h1543, 1'b1}, 8'h02, 0);
		add_row("chr_bank", 16'h5003, 8'h0B, 16'h8000, 14'h1C00, {13'h1540, 1'b0}, 8'h5F, 1);
		add_row("chr_mask", 16'h5004, 8'h03, 16'h8000, 14'h1000, {13'h1540, 1'b0}, 8'h44, 0);
		add_row("sram_page", 16'h5005, 8'hFB, 16'h6000, 14'h0000, 14'h0003, 8'h40, 0);
		add_row("mode", 16'h5007, 8'h0F, 16'h8000, 14'h0800, {13'h1542, 1'b0}, 8'h42, 1);
		add_row("mask_clear", 16'h5002, 8'h00, 16'hA000, 14'h0000, {13'h155E, 1'b1}, 8'h40, 0);
		// UxROM
		add_row("uxrom_id", 16'h5006, 8'h01, 16'h8000, 14'h0000, {13'h155E, 1'b0}, 8'h40, 0);
		add_row("uxrom_bank", 16'h8000, 8'h05, 16'hA000, 14'h0000, {13'h1545, 1'b1}, 8'h40, 0);
		add_row("uxrom_fixed", 16'hC000, 8'h0A, 16'hC000, 14'h0000, {13'h155F, 1'b0}, 8'h40, 0);
		add_row("uxrom_masked", 16'h5002, 8'h18, 16'hE000, 14'h0000, {13'h1547, 1'b1}, 8'h40, 0);
		// CNROM
		add_row("cnrom_id", 16'h5006, 8'h02, 16'h8000, 14'h0C00, {13'h1542, 1'b0}, 8'h43, 1);
		add_row("cnrom_bank", 16'h8000, 8'h16, 16'h8000, 14'h1400, {13'h1542, 1'b0}, 8'hA5, 0);
		add_row("cnrom_unmask", 16'h5002, 8'h00, 16'hE000, 14'h0800, {13'h155F, 1'b1}, 8'hA2, 1);
		for (i = 0; i < 3; i++)
		begin
			r = $random(seed);
			pa = {1'b0, r[12:0]};	// Pattern table space only
			add_row("cnrom_rand", 16'h8000, 8'h16, 16'h8000, pa, {13'h154A, 1'b0},
				{5'b10100, pa[12:10]}, pa[11]);
		end
		// AxROM 32K pages and one-screen mirroring
		add_row("axrom_id", 16'h5006, 8'h08, 16'h8000, 14'h0400, {13'h1554, 1'b0}, 8'hA1, 0);
		add_row("axrom_bank", 16'h8000, 8'h13, 16'hE000, 14'h0400, {13'h1547, 1'b1}, 8'hA1, 1);
		add_row("axrom_page0", 16'h8000, 8'h02, 16'hA000, 14'h0C00, {13'h1544, 1'b1}, 8'hA3, 0);
		// MMC3
		add_row("mmc3_id", 16'h5006, 8'h14, 16'h8000, 14'h0000, {13'h1540, 1'b0}, 8'h00, 0);
		add_row("chr_unmask", 16'h5004, 8'h00, 16'hE000, 14'h0000, {13'h155F, 1'b1}, 8'h00, 0);
		for (i = 0; i < 8; i++)
		begin
			add_write(16'h8000, 8'(i));	// Select R0-R7
			add_write(16'h8001, 8'h10 + 8'(i) * 8'h11);
		end
		add_row("mmc3_mirror", 16'hA000, 8'h01, 16'h8000, 14'h0800, {13'h155B, 1'b0}, 8'h20, 1);
		add_row("m3_p0_8000", 16'h8000, 8'h00, 16'h8000, 14'h0000, {13'h155B, 1'b0}, 8'h10, 0);
		add_row("m3_p0_a000", 16'h8000, 8'h00, 16'hA000, 14'h0C00, {13'h1543, 1'b1}, 8'h21, 1);
		add_row("m3_p0_c000", 16'h8000, 8'h00, 16'hC000, 14'h1000, {13'h155F, 1'b0}, 8'h32, 0);
		add_row("m3_p0_e000", 16'h8000, 8'h00, 16'hE000, 14'h1C00, {13'h155F, 1'b1}, 8'h65, 1);
		add_row("m3_p1_8000", 16'h8000, 8'h40, 16'h8000, 14'h1400, {13'h155F, 1'b0}, 8'h43, 0);
		add_row("m3_p1_c000", 16'h8000, 8'h40, 16'hC000, 14'h1800, {13'h155B, 1'b0}, 8'h54, 1);
		add_row("m3_c1_lo", 16'h8000, 8'h80, 16'hA000, 14'h0400, {13'h1543, 1'b1}, 8'h43, 0);
		add_row("m3_c1_hi", 16'h8000, 8'h80, 16'h8000, 14'h1800, {13'h155B, 1'b0}, 8'h20, 1);
		// Lockout drops later config writes
		add_row("lock_set", 16'h5007, 8'h8F, 16'h8000, 14'h0000, {13'h155B, 1'b0}, 8'h32, 0);
		add_row("lock_mapper", 16'h5006, 8'h01, 16'h8000, 14'h0000, {13'h155B, 1'b0}, 8'h32, 0);
		add_row("lock_base", 16'h5000, 8'h00, 16'hE000, 14'h1000, {13'h155F, 1'b1}, 8'h10, 0);
	endtask

	task automatic bus_write(input logic [15:0] wa, input logic [7:0] wd);
		@(negedge m2);
		romsel = ~wa[15];	// High below $8000
		cpu_addr_in = wa[14:0];
		cpu_data_in = wd;
		cpu_rw_in = 1'b0;
		@(negedge m2);	// Taken at the rising edge between
		cpu_rw_in = 1'b1;
	endtask

	task automatic apply_row(input int n);
		bus_write(q_wa[n], q_wd[n]);
		if (q_chk[n])
		begin
			romsel = ~q_pa[n][15];
			cpu_addr_in = q_pa[n][14:0];
			ppu_addr = q_ppu[n];
			@(posedge m2);
			#1;	// Mid high phase
			check_value({q_name[n], " cpu_addr_out"}, q_ecpu[n], cpu_addr_out);
			check_value({q_name[n], " ppu_addr_out"}, q_eppu[n], ppu_addr_out);
			check_value({q_name[n], " ppu_ciram_a10"}, q_ea10[n], ppu_ciram_a10);
			check_value({q_name[n], " flash_oe"}, !q_pa[n][15], flash_oe);	// Read, OE follows romsel
		end
	endtask

	task automatic check_strobes(input string name, input logic exp_ce, input logic exp_we,
		input logic exp_ppu_we);
		@(negedge m2);
		romsel = 1'b1;
		cpu_addr_in = 15'h6000;	// SRAM window
		cpu_rw_in = 1'b1;
		ppu_rd_in = 1'b0;
		ppu_wr_in = 1'b0;
		ppu_addr = 14'h0400;	// Pattern table
		@(posedge m2);
		#1;
		check_value({name, " sram_ce"}, exp_ce, sram_ce);
		check_value({name, " sram_we"}, 1'b1, sram_we);
		check_value({name, " sram_oe"}, 1'b0, sram_oe);
		check_value({name, " flash_oe"}, 1'b1, flash_oe);	// Not a ROM cycle
		check_value({name, " ppu_rd_out"}, 1'b0, ppu_rd_out);
		check_value({name, " ppu_wr_out"}, exp_ppu_we, ppu_wr_out);
		@(negedge m2);
		romsel = 1'b0;
		cpu_addr_in = 15'h2001;	// No register in any mapper used here
		cpu_rw_in = 1'b0;
		ppu_addr = 14'h2400;	// Nametable space, CHR strobes held off
		#2;
		check_value({name, " flash_we"}, exp_we, flash_we);
		check_value({name, " flash_oe write"}, 1'b1, flash_oe);
		check_value({name, " sram_we write"}, 1'b0, sram_we);
		check_value({name, " sram_oe write"}, 1'b1, sram_oe);
		check_value({name, " ppu_rd_out nametable"}, 1'b1, ppu_rd_out);
		check_value({name, " ppu_wr_out nametable"}, 1'b1, ppu_wr_out);
		@(negedge m2);
		cpu_rw_in = 1'b1;
		romsel = 1'b1;
		ppu_rd_in = 1'b1;
		ppu_wr_in = 1'b1;
		ppu_addr = 14'h0000;
	endtask

	task automatic a12_rise(input int lows);
		int k;
		for (k = 0; k < lows; k++)
		begin
			@(negedge m2);
			ppu_addr = 14'h0000;
		end
		@(negedge m2);
		ppu_addr = 14'h1000;
		@(posedge m2);
		#1;
	endtask

	task automatic wait_irq(input string what, input logic level);
		int n;
		n = 0;
		while (irq !== level && n < 20)	// Bounded poll
		begin
			@(posedge m2);
			#1;
			n++;
		end
		if (irq !== level)
		begin
			timeouts++;
			$display("Timeout: irq did not go to %b %s", level, what);
		end
	endtask

	initial
	begin
		romsel = 1'b1;
		cpu_rw_in = 1'b1;
		cpu_addr_in = '0;
		cpu_data_in = '0;
		ppu_addr_in = 1'b1;
		ppu_rd_in = 1'b1;
		ppu_wr_in = 1'b1;
		ppu_addr = '0;
		build_table();
		repeat (16) @(posedge m2);
		@(negedge m2);
		ppu_addr_in = 1'b0;
		check_value("reset irq", 1'b1, irq);
		check_strobes("reset", 1'b1, 1'b1, 1'b1);	// SRAM and flash writes off
		for (row = 0; row < q_name.size(); row++)
			apply_row(row);
		check_strobes("enabled", 1'b0, 1'b0, 1'b0);
		// Scanline IRQ with latch 3 needs four filtered rises
		@(negedge m2);
		ppu_addr = 14'h0000;
		bus_write(16'hC000, 8'd3);
		bus_write(16'hC001, 8'h00);	// Reload
		bus_write(16'hE001, 8'h00);	// Enable
		for (row = 0; row < 3; row++)
		begin
			a12_rise(4);
			check_value("irq before last rise", 1'b1, irq);
		end
		a12_rise(1);	// Too short a low time
		check_value("irq after short pulse", 1'b1, irq);
		a12_rise(4);
		wait_irq("after the last A12 rise", 1'b0);
		@(negedge m2);
		ppu_addr = 14'h0000;
		bus_write(16'hE000, 8'h00);	// Disable and acknowledge
		wait_irq("after the IRQ disable write", 1'b1);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
